// ==== verilog/snd_audio_pkg.sv ====
package snd_audio_pkg;

   // NR32[6:5] output level code
   typedef enum logic [1:0] {
      LVL_MUTE    = 2'd0,                         // silent
      LVL_FULL    = 2'd1,                         // sample as stored
      LVL_HALF    = 2'd2,                         // shifted right once
      LVL_QUARTER = 2'd3                          // shifted right twice
   } level_e;

   // codec slot width, unsigned
   typedef logic [19:0] sample_t;

   // output per unit of 4-bit amplitude
   // 15 steps give the full scale value 20'h1FFFE
   localparam sample_t AMP_STEP = 20'h02222;

endpackage

// ==== verilog/snd_regs_pkg.sv ====
package snd_regs_pkg;

   // word offsets on the bus
   typedef enum logic [4:0] {
      OFS_NR30      = 5'd0,                       // dac enable
      OFS_NR31      = 5'd1,                       // length load
      OFS_NR32      = 5'd2,                       // output level
      OFS_NR33      = 5'd3,                       // frequency low, write only
      OFS_NR34      = 5'd4,                       // trigger, length enable, frequency high
      OFS_WAVE_BASE = 5'd16                       // wave RAM spans 16..31
   } reg_offset_e;

   localparam int WAVE_BYTES = 16;                // 32 samples, two per byte

   // control fields decoded out of NR30..NR34
   typedef struct packed {
      logic                  dac_enable;          // NR30[7]
      logic [7:0]            length_load;         // NR31
      snd_audio_pkg::level_e level;               // NR32[6:5]
      logic [10:0]           frequency;           // {NR34[2:0], NR33}
      logic                  length_enable;       // NR34[6]
   } ch3_ctrl_t;

   // the sample with the even pointer sits in the upper half
   typedef struct packed {
      logic [3:0] hi_nibble;
      logic [3:0] lo_nibble;
   } wave_nibbles_t;

   // written by the bus as a byte, read by the sequencer as two samples
   typedef union packed {
      logic [7:0]    raw;
      wave_nibbles_t nibbles;
   } wave_byte_u;

endpackage

// ==== verilog/ch3_reg_decode.sv ====
`timescale 1ns/1ps

module ch3_reg_decode #(
   parameter int WB_ADR_W = 5
) (
   input  logic                      I_BITCLK,
   input  logic                      I_RESET,
   input  logic                      wb_cyc,
   input  logic                      wb_stb,
   input  logic                      wb_we,
   input  logic [WB_ADR_W-1:0]       wb_adr,
   input  logic [7:0]                wb_dat_w,
   output logic [7:0]                wb_dat_r,
   output logic                      wb_ack,
   output snd_regs_pkg::ch3_ctrl_t   ctrl,
   output logic                      trigger,
   input  logic [3:0]                wave_addr,
   output snd_regs_pkg::wave_byte_u  wave_byte
);
   import snd_regs_pkg::*;
   import snd_audio_pkg::*;

   logic        adr_in_page;                      // upper address bits all zero
   logic [4:0]  adr_ofs;
   logic        bus_req;                          // cycle not yet acknowledged
   logic        bus_wr;
   wave_byte_u  wave_ram [WAVE_BYTES];

   assign adr_ofs     = wb_adr[4:0];
   assign adr_in_page = (wb_adr >> 5) == '0;
   assign bus_req     = wb_cyc & wb_stb & ~wb_ack;   // ack drops for a cycle between beats
   assign bus_wr      = bus_req & wb_we & adr_in_page;

   // sequencer read port
   assign wave_byte = wave_ram[wave_addr];

   always_ff @(posedge I_BITCLK) begin
      if (I_RESET) begin
         wb_ack  <= 1'b0;
         trigger <= 1'b0;
         ctrl    <= '0;
         for (int i = 0; i < WAVE_BYTES; i++) begin
            wave_ram[i] <= '0;
         end
      end else begin
         wb_ack  <= bus_req;
         trigger <= bus_wr && (adr_ofs == OFS_NR34) && wb_dat_w[7];
         if (bus_wr) begin
            if (adr_ofs[4]) begin
               wave_ram[adr_ofs[3:0]].raw <= wb_dat_w;
            end else begin
               case (reg_offset_e'(adr_ofs))
                  OFS_NR30: ctrl.dac_enable      <= wb_dat_w[7];
                  OFS_NR31: ctrl.length_load     <= wb_dat_w;
                  OFS_NR32: ctrl.level           <= level_e'(wb_dat_w[6:5]);
                  OFS_NR33: ctrl.frequency[7:0]  <= wb_dat_w;
                  OFS_NR34: begin
                     ctrl.length_enable   <= wb_dat_w[6];
                     ctrl.frequency[10:8] <= wb_dat_w[2:0];
                  end
                  default: ;                      // unmapped, ack only
               endcase
            end
         end
      end
   end

   // read mux, held valid while ack is high since the master keeps adr stable
   always_comb begin
      wb_dat_r = 8'hFF;
      if (adr_in_page) begin
         if (adr_ofs[4]) begin
            wb_dat_r = wave_ram[adr_ofs[3:0]].raw;
         end else begin
            case (reg_offset_e'(adr_ofs))
               OFS_NR30: wb_dat_r = {ctrl.dac_enable, 7'h7F};
               OFS_NR31: wb_dat_r = ctrl.length_load;
               OFS_NR32: wb_dat_r = {1'b1, ctrl.level, 5'h1F};
               OFS_NR34: wb_dat_r = {1'b1, ctrl.length_enable, 3'b111, ctrl.frequency[10:8]};
               default:  wb_dat_r = 8'hFF;        // NR33 is write only
            endcase
         end
      end
   end

   // an ack always answers a request seen on the previous edge
   ack_needs_request : assert property (
      @(posedge I_BITCLK) disable iff (I_RESET)
      $rose(wb_ack) |-> $past(wb_cyc & wb_stb)
   ) else $error("wb_ack raised without cyc and stb");

   // single cycle ack, then one idle cycle
   ack_single_cycle : assert property (
      @(posedge I_BITCLK) disable iff (I_RESET)
      wb_ack |=> !wb_ack
   ) else $error("wb_ack high on two consecutive cycles");

endmodule

// ==== verilog/ch3_wave_sequencer.sv ====
`timescale 1ns/1ps

module ch3_wave_sequencer #(
   parameter int LENGTH_DIV = 188
) (
   input  logic                    I_BITCLK,
   input  logic                    I_RESET,
   input  logic                    I_STROBE,
   input  snd_regs_pkg::ch3_ctrl_t ctrl,
   input  logic                    trigger,
   output logic [3:0]              wave_addr,
   output logic                    nibble_sel,
   output logic                    playing
);

   localparam int DIV_W = (LENGTH_DIV > 1) ? $clog2(LENGTH_DIV) : 1;

   logic [4:0]       sample_ptr;
   logic [11:0]      period_cnt;                  // strobes left on this sample
   logic [11:0]      period_load;
   logic [8:0]       length_cnt;                  // length ticks left
   logic [8:0]       len_load;
   logic [DIV_W-1:0] div_cnt;
   logic             div_tick;                    // one length tick
   logic             len_expired;

   // the channel timer holds each sample for 2048 - frequency strobes
   assign period_load = 12'd2048 - {1'b0, ctrl.frequency};
   assign len_load    = 9'd256 - {1'b0, ctrl.length_load};
   assign div_tick    = I_STROBE && (div_cnt == DIV_W'(LENGTH_DIV - 1));

   // stop on the edge where the counter hits zero
   assign len_expired = ctrl.length_enable &&
                        ((length_cnt == '0) || (div_tick && length_cnt == 9'd1));

   always_ff @(posedge I_BITCLK) begin
      if (I_RESET) begin
         sample_ptr <= '0;
         period_cnt <= '0;
         length_cnt <= '0;
         div_cnt    <= '0;
         playing    <= 1'b0;
      end else if (trigger) begin                 // restart, also mid playback
         sample_ptr <= '0;
         period_cnt <= period_load;
         length_cnt <= len_load;
         div_cnt    <= '0;
         playing    <= 1'b1;
      end else begin
         if (I_STROBE) begin
            div_cnt <= div_tick ? '0 : div_cnt + 1'b1;
         end
         if (div_tick && length_cnt != '0) begin
            length_cnt <= length_cnt - 1'b1;
         end
         if (I_STROBE && playing) begin
            if (period_cnt == 12'd1) begin
               period_cnt <= period_load;         // picks up a new frequency here
               sample_ptr <= sample_ptr + 1'b1;   // wraps at 32
            end else begin
               period_cnt <= period_cnt - 1'b1;
            end
         end
         if (len_expired) begin
            playing <= 1'b0;
         end
      end
   end

   assign wave_addr  = sample_ptr[4:1];
   assign nibble_sel = sample_ptr[0];

   // pointer moves only on a strobe or a trigger from the bus side
   ptr_moves_on_event : assert property (
      @(posedge I_BITCLK) disable iff (I_RESET)
      (!$stable(sample_ptr) && !$past(I_RESET)) |-> $past(I_STROBE || trigger)
   ) else $error("sample pointer changed without strobe or trigger");

   play_needs_trigger : assert property (
      @(posedge I_BITCLK) disable iff (I_RESET)
      $rose(playing) |-> $past(trigger)
   ) else $error("playing rose without a trigger");

endmodule

// ==== verilog/ch3_level_output.sv ====
`timescale 1ns/1ps

module ch3_level_output (
   input  logic                     I_BITCLK,
   input  logic                     I_RESET,
   input  snd_regs_pkg::ch3_ctrl_t  ctrl,
   input  snd_regs_pkg::wave_byte_u wave_byte,
   input  logic                     nibble_sel,
   input  logic                     playing,
   output snd_audio_pkg::sample_t   ch3_waveform,
   output logic                     ch3_on
);
   import snd_audio_pkg::*;

   logic [3:0] nibble;
   logic [3:0] scaled;                            // after the level shift
   logic       chan_on;
   sample_t    sample_next;

   // even pointer takes the upper half
   assign nibble = nibble_sel ? wave_byte.nibbles.lo_nibble : wave_byte.nibbles.hi_nibble;

   always_comb begin
      case (ctrl.level)
         LVL_FULL:    scaled = nibble;
         LVL_HALF:    scaled = nibble >> 1;
         LVL_QUARTER: scaled = nibble >> 2;
         default:     scaled = 4'd0;              // mute
      endcase
   end

   assign chan_on     = ctrl.dac_enable & playing;
   assign sample_next = chan_on ? AMP_STEP * scaled : '0;

   always_ff @(posedge I_BITCLK) begin
      if (I_RESET) begin
         ch3_on       <= 1'b0;
         ch3_waveform <= '0;
      end else begin
         ch3_on       <= chan_on;
         ch3_waveform <= sample_next;
      end
   end

   silent_when_off : assert property (
      @(posedge I_BITCLK) disable iff (I_RESET)
      !ch3_on |-> (ch3_waveform == '0)
   ) else $error("ch3_waveform nonzero while channel is off");

endmodule

// ==== verilog/sound_channel3_top.sv ====
`timescale 1ns/1ps

module sound_channel3_top #(
   parameter int LENGTH_DIV = 188,
   parameter int WB_ADR_W   = 5
) (
   input  logic                   I_BITCLK,
   input  logic                   I_RESET,
   input  logic                   I_STROBE,
   input  logic                   wb_cyc,
   input  logic                   wb_stb,
   input  logic                   wb_we,
   input  logic [WB_ADR_W-1:0]    wb_adr,
   input  logic [7:0]             wb_dat_w,
   output logic [7:0]             wb_dat_r,
   output logic                   wb_ack,
   output snd_audio_pkg::sample_t ch3_waveform,
   output logic                   ch3_on
);
   import snd_regs_pkg::*;

   ch3_ctrl_t  ctrl;
   wave_byte_u wave_byte;
   logic       trigger;
   logic [3:0] wave_addr;
   logic       nibble_sel;
   logic       playing;

   ch3_reg_decode #(
      .WB_ADR_W (WB_ADR_W)
   ) u_decode (
      .I_BITCLK  (I_BITCLK),
      .I_RESET   (I_RESET),
      .wb_cyc    (wb_cyc),
      .wb_stb    (wb_stb),
      .wb_we     (wb_we),
      .wb_adr    (wb_adr),
      .wb_dat_w  (wb_dat_w),
      .wb_dat_r  (wb_dat_r),
      .wb_ack    (wb_ack),
      .ctrl      (ctrl),
      .trigger   (trigger),
      .wave_addr (wave_addr),
      .wave_byte (wave_byte)
   );

   ch3_wave_sequencer #(
      .LENGTH_DIV (LENGTH_DIV)
   ) u_execute (
      .I_BITCLK   (I_BITCLK),
      .I_RESET    (I_RESET),
      .I_STROBE   (I_STROBE),
      .ctrl       (ctrl),
      .trigger    (trigger),
      .wave_addr  (wave_addr),
      .nibble_sel (nibble_sel),
      .playing    (playing)
   );

   ch3_level_output u_result (
      .I_BITCLK     (I_BITCLK),
      .I_RESET      (I_RESET),
      .ctrl         (ctrl),
      .wave_byte    (wave_byte),
      .nibble_sel   (nibble_sel),
      .playing      (playing),
      .ch3_waveform (ch3_waveform),
      .ch3_on       (ch3_on)
   );

endmodule

// ==== test/tb_sound_channel3.sv ====
`timescale 1ns/1ps

module tb_sound_channel3;

   localparam int          LEN_DIV  = 4;
   localparam int          NUM_ROWS = 8;
   localparam logic [19:0] STEP     = 20'h02222;  // output per unit of amplitude

   typedef struct packed {
      logic [10:0] freq;
      logic [1:0]  level;
      logic [7:0]  len_load;
      logic        len_en;
      logic        dac;
      logic [15:0] strobes;                       // strobes observed after the trigger
   } row_t;

   logic        I_BITCLK = 1'b0;
   logic        I_RESET  = 1'b1;
   logic        I_STROBE = 1'b0;
   logic        wb_cyc   = 1'b0;
   logic        wb_stb   = 1'b0;
   logic        wb_we    = 1'b0;
   logic [4:0]  wb_adr   = '0;
   logic [7:0]  wb_dat_w = '0;
   logic [7:0]  wb_dat_r;
   logic        wb_ack;
   logic [19:0] ch3_waveform;
   logic        ch3_on;

   row_t        rows [NUM_ROWS];
   logic [7:0]  wave_mem [16];                    // own copy of the wave RAM
   logic [31:0] lfsr        = 32'h2007;
   logic        strobe_seen = 1'b0;               // strobe sampled at the last edge
   int          phase, checks, value_errors, bus_errors, timeouts;
   int          cycle_count, cycle_limit;

   always #10 I_BITCLK = ~I_BITCLK;

   sound_channel3_top #(
      .LENGTH_DIV (LEN_DIV),
      .WB_ADR_W   (5)
   ) UUT (
      .I_BITCLK     (I_BITCLK),
      .I_RESET      (I_RESET),
      .I_STROBE     (I_STROBE),
      .wb_cyc       (wb_cyc),
      .wb_stb       (wb_stb),
      .wb_we        (wb_we),
      .wb_adr       (wb_adr),
      .wb_dat_w     (wb_dat_w),
      .wb_dat_r     (wb_dat_r),
      .wb_ack       (wb_ack),
      .ch3_waveform (ch3_waveform),
      .ch3_on       (ch3_on)
   );

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);  // x^32+x^22+x^2+x+1
   endfunction

   function automatic logic [7:0] next_byte();
      logic [7:0] b;
      for (int i = 0; i < 8; i++) begin
         lfsr = lfsr_step(lfsr);
         b[i] = lfsr[0];
      end
      return b;
   endfunction

   function automatic row_t make_row(input int freq, input int level, input int len_load,
                                     input bit len_en, input bit dac, input int strobes);
      row_t r;
      r.freq     = 11'(freq);
      r.level    = 2'(level);
      r.len_load = 8'(len_load);
      r.len_en   = len_en;
      r.dac      = dac;
      r.strobes  = 16'(strobes);
      return r;
   endfunction

   // mute, full, half, quarter
   function automatic logic [19:0] scaled_sample(input logic [3:0] nib, input logic [1:0] level);
      logic [3:0] s;
      s = (level == 2'd0) ? 4'd0 : nib >> (level - 2'd1);
      return STEP * s;
   endfunction

   task automatic check_val(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
      checks++;
      assert (expected === actual) else begin
         value_errors++;
         $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
      end
   endtask

   // one clock, inputs change 2 ns after the edge
   task automatic step_cycle();
      @(posedge I_BITCLK);
      #2;
      strobe_seen = I_STROBE;
      phase       = (phase + 1) % 4;
      I_STROBE    = (phase == 0);
   endtask

   task automatic bus_access(input logic we, input logic [4:0] adr, input logic [7:0] wdata,
                             output logic [7:0] rdata);
      int waited;
      waited   = 0;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = wdata;
      do begin
         step_cycle();
         waited++;
      end while (!wb_ack && waited < 8);
      rdata = wb_dat_r;                           // valid while ack is high
      assert (wb_ack) else begin
         bus_errors++;
         $display("bus timeout, no ack for offset %0d at %0t", adr, $time);
      end
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      step_cycle();
      assert (!wb_ack) else begin
         bus_errors++;
         $display("more than one ack for one access to offset %0d at %0t", adr, $time);
      end
   endtask

   task automatic bus_write(input logic [4:0] adr, input logic [7:0] data);
      logic [7:0] unused;
      bus_access(1'b1, adr, data, unused);
   endtask

   task automatic check_readback(input logic [4:0] adr, input logic [7:0] data,
                                 input logic [7:0] ones_mask);
      logic [7:0] rd;
      bus_write(adr, data);
      bus_access(1'b0, adr, 8'h00, rd);
      check_val($sformatf("wb_dat_r[ofs %0d]", adr), data | ones_mask, rd);
   endtask

   task automatic program_and_trigger(input int r);
      bus_write(5'd0, {rows[r].dac, 7'h00});
      bus_write(5'd1, rows[r].len_load);
      bus_write(5'd2, {1'b0, rows[r].level, 5'h00});
      bus_write(5'd3, rows[r].freq[7:0]);
      bus_write(5'd4, {1'b1, rows[r].len_en, 3'b000, rows[r].freq[10:8]});
      step_cycle();                               // output register lags the trigger
   endtask

   // pointer follows the strobe count since the output came up
   task automatic observe_row(input int r);
      int         n;
      int         period;
      int         len_stop;
      int         ptr;
      logic [7:0] b;
      logic [3:0] nib;
      logic       exp_on;
      n        = 0;
      period   = 2048 - rows[r].freq;
      len_stop = (256 - rows[r].len_load) * LEN_DIV;
      while (n < rows[r].strobes) begin
         ptr    = (n / period) % 32;
         b      = wave_mem[ptr / 2];
         nib    = (ptr % 2) ? b[3:0] : b[7:4];  // high nibble first
         exp_on = rows[r].dac && !(rows[r].len_en && n >= len_stop);
         check_val("ch3_on", exp_on, ch3_on);
         check_val("ch3_waveform", exp_on ? scaled_sample(nib, rows[r].level) : 20'h0,
                   ch3_waveform);
         if (strobe_seen) begin
            n++;
         end
         step_cycle();
      end
   endtask

   task automatic report_and_finish();
      $display("checks %0d, value errors %0d, bus errors %0d, timeouts %0d",
               checks, value_errors, bus_errors, timeouts);
      if (value_errors == 0 && bus_errors == 0 && timeouts == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   endtask

   always @(posedge I_BITCLK) begin
      cycle_count++;
      if (cycle_count > cycle_limit) begin
         timeouts++;
         $display("run did not finish within %0d cycles", cycle_limit);
         report_and_finish();
      end
   end

   initial begin
      logic [7:0] rd;
      rows[0] = make_row(2046, 1, 0,   1'b0, 1'b1, 80);  // wraps past 32 samples
      rows[1] = make_row(2045, 2, 0,   1'b0, 1'b1, 48);  // retrigger while playing
      rows[2] = make_row(2044, 3, 0,   1'b0, 1'b1, 40);
      rows[3] = make_row(2046, 0, 0,   1'b0, 1'b1, 16);  // mute
      rows[4] = make_row(2046, 1, 0,   1'b0, 1'b0, 16);  // dac off
      rows[5] = make_row(2047, 1, 250, 1'b1, 1'b1, 32);  // stops after 24 strobes
      rows[6] = make_row(2046, 2, 252, 1'b1, 1'b1, 24);
      rows[7] = make_row(2045, 1, 250, 1'b0, 1'b1, 40);  // length ignored
      cycle_limit = 2000;
      for (int r = 0; r < NUM_ROWS; r++) begin
         cycle_limit += 2 * rows[r].strobes * 4;
      end

      repeat (16) step_cycle();
      I_RESET = 1'b0;
      step_cycle();
      check_val("ch3_on", 1'b0, ch3_on);
      check_val("ch3_waveform", 20'h0, ch3_waveform);
      bus_access(1'b0, 5'd16, 8'h00, rd);
      check_val("wb_dat_r[ofs 16]", 8'h00, rd);

      check_readback(5'd0, 8'h80, 8'h7F);
      check_readback(5'd0, 8'h00, 8'h7F);
      check_readback(5'd1, 8'hA5, 8'h00);
      check_readback(5'd2, 8'h40, 8'h9F);
      check_readback(5'd4, 8'h45, 8'hB8);         // bit 7 clear, no trigger
      check_readback(5'd3, 8'h12, 8'hFF);         // write only
      check_readback(5'd9, 8'h3C, 8'hFF);
      check_readback(5'd15, 8'h00, 8'hFF);

      for (int i = 0; i < 16; i++) begin
         wave_mem[i] = next_byte();
         bus_write(5'(16 + i), wave_mem[i]);
      end
      for (int i = 0; i < 16; i++) begin
         bus_access(1'b0, 5'(16 + i), 8'h00, rd);
         check_val($sformatf("wb_dat_r[ofs %0d]", 16 + i), wave_mem[i], rd);
      end

      for (int r = 0; r < NUM_ROWS; r++) begin
         program_and_trigger(r);
         observe_row(r);
      end
      report_and_finish();
   end

endmodule

// ==== tb.f ====
verilog/snd_audio_pkg.sv
verilog/snd_regs_pkg.sv
verilog/ch3_reg_decode.sv
verilog/ch3_wave_sequencer.sv
verilog/ch3_level_output.sv
verilog/sound_channel3_top.sv
test/tb_sound_channel3.sv
